// ==== Makefile ====
TOP := arb_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all sim lint clean

all: sim

$(OBJ)/V$(TOP): sim.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir $(OBJ)

# the run passes only when the log holds the pass line
sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	verilator --lint-only --top-module arb_top verilog/arb_pkg.sv verilog/pipe_stage.sv \
		verilog/tree_node.sv verilog/tag_tree.sv verilog/req_port_bank.sv verilog/arb_top.sv

clean:
	rm -rf $(OBJ) $(LOG)

// ==== sim.f ====
verilog/arb_pkg.sv
verilog/pipe_stage.sv
verilog/tree_node.sv
verilog/tag_tree.sv
verilog/req_port_bank.sv
verilog/arb_top.sv
tb/arb_properties.sv
tb/arb_tb.sv

// ==== tb/arb_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module arb_properties (
   input logic                      clk,
   input logic                      rst_n_i,
   input logic                      out_valid_i,
   input arb_pkg::grant_t           out_grant_i,
   input logic                      out_ready_i,
   input logic [arb_pkg::N_REQ-1:0] tree_ack_i,
   input logic [arb_pkg::N_REQ-1:0] slot_full_i
);

   logic [arb_pkg::N_REQ-1:0] grant_bit;

   // the slot named by the grant that the output stage holds
   always_comb begin
      grant_bit                  = '0;
      grant_bit[out_grant_i.tag] = 1'b1;
   end

   // a stalled grant stays on the output unchanged until it is taken
   property grant_held_p;
      @(posedge clk) disable iff (!rst_n_i)
         ($past(rst_n_i) && $past(out_valid_i) && !$past(out_ready_i))
            |-> (out_valid_i && (out_grant_i == $past(out_grant_i)));
   endproperty

   grant_held_a : assert property (grant_held_p)
      else $error("out_grant_o changed while the output was stalled");

   // a released slot is exactly the one whose grant entered the output stage
   ack_onehot_a : assert property (@(posedge clk) disable iff (!rst_n_i)
      (tree_ack_i != '0) |=> (out_valid_i && ($past(tree_ack_i) == grant_bit)))
      else $error("the acked slot does not match the grant that left the tree");

   ack_full_a : assert property (@(posedge clk) disable iff (!rst_n_i)
      ((tree_ack_i & ~slot_full_i) == '0))
      else $error("ack reached an empty slot");

endmodule

`default_nettype wire

// ==== tb/arb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arb_tb;

   localparam int N            = arb_pkg::N_REQ;
   localparam int RANDOM_WORDS = 300;
   // 20 cycles for every word the tests drive, plus room for reset
   localparam int WATCHDOG_CYCLES = (1 + 2 * N + RANDOM_WORDS) * 20 + 100;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic [N-1:0]           req_valid;
   arb_pkg::data_t [N-1:0] req_data;
   logic [N-1:0]           req_ready;
   logic                   out_valid;
   arb_pkg::grant_t        out_grant;
   logic                   out_ready;

   logic [31:0]            lcg_state = 32'h5588_ffbb;
   arb_pkg::data_t         sb_q [N][$];
   int                     grant_count = 0;
   logic [N-1:0]           seen_tags = '0;
   arb_pkg::grant_t        last_grant;

   always #50 clk = ~clk;

   arb_top dut_i (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .req_valid_i (req_valid),
      .req_data_i  (req_data),
      .req_ready_o (req_ready),
      .out_valid_o (out_valid),
      .out_grant_o (out_grant),
      .out_ready_i (out_ready)
   );

   bind arb_top arb_properties props_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .out_valid_i (out_valid_o),
      .out_grant_i (out_grant_o),
      .out_ready_i (out_ready_i),
      .tree_ack_i  (tree_ack),
      .slot_full_i (slot_full)
   );

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare_grant(input string name, input arb_pkg::grant_t actual,
                                input arb_pkg::grant_t expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is tag %0d data %h, expected tag %0d data %h",
                  $time, name, actual.tag, actual.data, expected.tag, expected.data);
         abort_run();
      end
   endtask

   task automatic compare_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_ready(input logic [N-1:0] expected);
      for (int k = 0; k < N; k++) begin
         compare_bit($sformatf("req_ready_o[%0d]", k), req_ready[k], expected[k]);
      end
   endtask

   // words enter the scoreboard on the requester handshake, grants leave it
   always @(negedge clk) begin : scoreboard_monitor
      arb_pkg::grant_t expected;
      if (rst_n) begin
         for (int k = 0; k < N; k++) begin
            if (req_valid[k] && req_ready[k]) begin
               sb_q[k].push_back(req_data[k]);
            end
         end
         if (out_valid && out_ready) begin
            if (sb_q[out_grant.tag].size() == 0) begin
               $display("Grant for requester %0d at %0t has no word waiting for it",
                        out_grant.tag, $time);
               abort_run();
            end else begin
               expected.tag  = out_grant.tag;
               expected.data = sb_q[out_grant.tag].pop_front();
               compare_grant("out_grant_o", out_grant, expected);
               seen_tags[out_grant.tag] = 1'b1;
               last_grant = out_grant;
               grant_count++;
            end
         end
      end
   end

   task automatic wait_grants(input int target);
      int waited;
      waited = 0;
      while (grant_count < target && waited < 500) begin
         @(posedge clk);
         waited++;
      end
      if (grant_count < target) begin
         $display("Only %0d of %0d grants arrived by %0t", grant_count, target, $time);
         abort_run();
      end
   endtask

   task automatic check_drained();
      for (int k = 0; k < N; k++) begin
         if (sb_q[k].size() != 0) begin
            $display("Requester %0d still waits for %0d words", k, sb_q[k].size());
            abort_run();
         end
      end
   endtask

   task automatic load_all_slots(input arb_pkg::data_t base, input logic ready);
      @(posedge clk);
      out_ready <= ready;
      for (int k = 0; k < N; k++) begin
         req_valid[k] <= 1'b1;
         req_data[k]  <= base + arb_pkg::data_t'(k * 16'h0111);
      end
      // every slot is empty here, so all words move at the next edge
      @(negedge clk);
      check_ready('1);
      @(posedge clk);
      req_valid <= '0;
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      compare_bit("out_valid_o", out_valid, 1'b0);
      check_ready('1);
   endtask

   task automatic test_single_request();
      arb_pkg::grant_t expected;
      int              start;
      start = grant_count;
      @(posedge clk);
      out_ready    <= 1'b1;
      req_valid[5] <= 1'b1;
      req_data[5]  <= 16'h5a3c;
      @(negedge clk);
      compare_bit("req_ready_o[5]", req_ready[5], 1'b1);
      @(posedge clk);
      req_valid[5] <= 1'b0;
      wait_grants(start + 1);
      expected.tag  = 3'd5;
      expected.data = 16'h5a3c;
      compare_grant("out_grant_o", last_grant, expected);
      @(negedge clk);
      compare_bit("req_ready_o[5]", req_ready[5], 1'b1);
   endtask

   task automatic test_full_load();
      int start;
      start     = grant_count;
      seen_tags = '0;
      load_all_slots(16'ha000, 1'b1);
      wait_grants(start + N);
      compare_bit("seen_tags (every requester granted)", &seen_tags, 1'b1);
      check_drained();
   endtask

   task automatic test_back_pressure();
      arb_pkg::grant_t held;
      logic [N-1:0]    ready_exp;
      int              start;
      start = grant_count;
      load_all_slots(16'h3000, 1'b0);
      @(negedge clk);
      while (!out_valid) begin
         @(negedge clk);
      end
      // only the slot of the grant now waiting at the output has emptied
      held                = out_grant;
      ready_exp           = '0;
      ready_exp[held.tag] = 1'b1;
      repeat (12) begin
         @(negedge clk);
         compare_bit("out_valid_o", out_valid, 1'b1);
         compare_grant("out_grant_o", out_grant, held);
         check_ready(ready_exp);
      end
      @(posedge clk);
      out_ready <= 1'b1;
      wait_grants(start + N);
      check_drained();
   endtask

   task automatic test_random_traffic();
      logic [N-1:0] taken;
      logic [31:0]  r;
      int           offered;
      int           start;
      offered = 0;
      start   = grant_count;
      @(negedge clk);
      while (offered < RANDOM_WORDS || req_valid != '0) begin
         taken = req_valid & req_ready;
         @(posedge clk);
         for (int k = 0; k < N; k++) begin
            // a requester keeps its word on offer until its slot takes it
            if (!req_valid[k] || taken[k]) begin
               r = next_random();
               if (offered < RANDOM_WORDS && r[31:30] != 2'b00) begin
                  req_valid[k] <= 1'b1;
                  req_data[k]  <= r[23:8];
                  offered++;
               end else begin
                  req_valid[k] <= 1'b0;
               end
            end
         end
         r = next_random();
         out_ready <= (r[31:30] != 2'b00);
         @(negedge clk);
      end
      @(posedge clk);
      out_ready <= 1'b1;
      wait_grants(start + RANDOM_WORDS);
      check_drained();
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   initial begin
      rst_n     = 1'b0;
      req_valid = '0;
      req_data  = '0;
      out_ready = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      test_single_request();
      test_full_load();
      test_back_pressure();
      test_random_traffic();
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

   // number of requesters that share the output
   localparam int N_REQ = 8;

   // a tag numbers one requester, so it must cover N_REQ values
   localparam int TAG_W = 3;

   localparam int DATA_W = 16;

   // with 0 the tree has no delay stages, 1 puts one on every second level
   // and 2 puts one on every level
   localparam int DELAY_CONF = 1;

   typedef logic [TAG_W-1:0] tag_t;

   typedef logic [DATA_W-1:0] data_t;

   // one arbitration result, the winning requester and its word
   typedef struct packed {
      tag_t  tag;
      data_t data;
   } grant_t;

endpackage

`default_nettype wire

// ==== verilog/arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arb_top (
   input  logic                                clk,
   input  logic                                rst_n_i,

   input  logic [arb_pkg::N_REQ-1:0]           req_valid_i,
   input  arb_pkg::data_t [arb_pkg::N_REQ-1:0] req_data_i,
   output logic [arb_pkg::N_REQ-1:0]           req_ready_o,

   output logic                                out_valid_o,
   output arb_pkg::grant_t                     out_grant_o,
   input  logic                                out_ready_i
);

   logic [arb_pkg::N_REQ-1:0] slot_full;
   logic [arb_pkg::N_REQ-1:0] tree_ack;
   arb_pkg::tag_t             root_tag;
   logic                      root_rdy;
   logic                      root_ack;
   arb_pkg::data_t            sel_data;
   arb_pkg::grant_t           root_grant;

   req_port_bank bank_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_data_i  (req_data_i),
      .req_ready_o (req_ready_o),
      .full_o      (slot_full),
      .ack_i       (tree_ack),
      .sel_tag_i   (root_tag),
      .sel_data_o  (sel_data)
   );

   tag_tree tree_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .rdy_in_i  (slot_full),
      .ack_out_o (tree_ack),
      .tag_o     (root_tag),
      .rdy_o     (root_rdy),
      .ack_i     (root_ack)
   );

   // the root tag and the word of its slot form one grant
   assign root_grant.tag  = root_tag;
   assign root_grant.data = sel_data;

   pipe_stage #(
      .payload_t (arb_pkg::grant_t)
   ) out_stage_i (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .in_rdy_i      (root_rdy),
      .in_payload_i  (root_grant),
      .in_ack_o      (root_ack),
      .out_rdy_o     (out_valid_o),
      .out_payload_o (out_grant_o),
      .out_ack_i     (out_ready_i)
   );

endmodule

`default_nettype wire

// ==== verilog/pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n_i,

   input  logic     in_rdy_i,
   input  payload_t in_payload_i,
   output logic     in_ack_o,

   output logic     out_rdy_o,
   output payload_t out_payload_o,
   input  logic     out_ack_i
);

   logic     full_q;
   payload_t payload_q;

   // room for a new item when empty, or when the held item leaves this cycle
   assign in_ack_o = ~full_q | out_ack_i;

   assign out_rdy_o     = full_q;
   assign out_payload_o = payload_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
      end else if (in_rdy_i && in_ack_o) begin
         full_q <= 1'b1;
      end else if (out_ack_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_rdy_i && in_ack_o) begin
         payload_q <= in_payload_i;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/req_port_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_port_bank (
   input  logic                                      clk,
   input  logic                                      rst_n_i,

   input  logic [arb_pkg::N_REQ-1:0]                 req_valid_i,
   input  arb_pkg::data_t [arb_pkg::N_REQ-1:0]       req_data_i,
   output logic [arb_pkg::N_REQ-1:0]                 req_ready_o,

   output logic [arb_pkg::N_REQ-1:0]                 full_o,
   input  logic [arb_pkg::N_REQ-1:0]                 ack_i,

   input  arb_pkg::tag_t                             sel_tag_i,
   output arb_pkg::data_t                            sel_data_o
);

   arb_pkg::data_t            data_q [arb_pkg::N_REQ];
   logic [arb_pkg::N_REQ-1:0] full_q;
   logic [arb_pkg::N_REQ-1:0] load;

   // an empty slot takes the requester's word right away
   assign req_ready_o = ~full_q;
   assign load        = req_valid_i & ~full_q;

   assign full_o = full_q;

   // a slot is acked only while full, so load and clear never meet
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         full_q <= '0;
      end else begin
         full_q <= (full_q & ~ack_i) | load;
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < arb_pkg::N_REQ; k++) begin
         if (load[k]) begin
            data_q[k] <= req_data_i[k];
         end
      end
   end

   // the word stays in its slot until the grant has left the root
   assign sel_data_o = data_q[sel_tag_i];

endmodule

`default_nettype wire

// ==== verilog/tag_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_tree (
   input  logic                      clk,
   input  logic                      rst_n_i,

   input  logic [arb_pkg::N_REQ-1:0] rdy_in_i,
   output logic [arb_pkg::N_REQ-1:0] ack_out_o,

   output arb_pkg::tag_t             tag_o,
   output logic                      rdy_o,
   input  logic                      ack_i
);

   if (arb_pkg::N_REQ == 1) begin : g_single
      // one requester needs no arbitration
      assign tag_o        = '0;
      assign rdy_o        = rdy_in_i[0];
      assign ack_out_o[0] = ack_i;
   end else begin : g_tree
      // leaves sit at 0 to N_REQ-1 and node k drives entry k+N_REQ
      arb_pkg::tag_t             node_tag [2*arb_pkg::N_REQ-1];
      logic                      node_rdy [2*arb_pkg::N_REQ-1];
      logic                      node_ack [2*arb_pkg::N_REQ-1];
      logic [arb_pkg::N_REQ-1:0] pend_q;
      logic [arb_pkg::N_REQ-1:0] leaf_ack;
      logic [arb_pkg::N_REQ-1:0] root_take;

      for (genvar k = 0; k < arb_pkg::N_REQ; k++) begin : g_leaf
         assign node_tag[k] = arb_pkg::tag_t'(k);
         // a leaf whose tag is already in flight is not offered again
         assign node_rdy[k]  = rdy_in_i[k] & ~pend_q[k];
         assign leaf_ack[k]  = node_ack[k];
         assign root_take[k] = rdy_o & ack_i & (tag_o == arb_pkg::tag_t'(k));
      end

      // the slot is released only when its tag leaves the root
      assign ack_out_o = root_take;

      // a clear at the root wins over a new leaf ack in a combinational tree
      always_ff @(posedge clk) begin
         if (!rst_n_i) begin
            pend_q <= '0;
         end else begin
            pend_q <= (pend_q | leaf_ack) & ~root_take;
         end
      end

      for (genvar k = 0; k < arb_pkg::N_REQ-1; k++) begin : g_node
         tree_node #(
            .enable_delay ((arb_pkg::DELAY_CONF == 2) ||
                           ((arb_pkg::DELAY_CONF == 1) &&
                            ($clog2(arb_pkg::N_REQ-k) % 2 == 1)))
         ) node_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .left_tag_i  (node_tag[2*k]),
            .left_rdy_i  (node_rdy[2*k]),
            .left_ack_o  (node_ack[2*k]),
            .right_tag_i (node_tag[2*k+1]),
            .right_rdy_i (node_rdy[2*k+1]),
            .right_ack_o (node_ack[2*k+1]),
            .tag_o       (node_tag[k+arb_pkg::N_REQ]),
            .rdy_o       (node_rdy[k+arb_pkg::N_REQ]),
            .ack_i       (node_ack[k+arb_pkg::N_REQ])
         );
      end

      // the root is the last entry
      assign tag_o                           = node_tag[2*arb_pkg::N_REQ-2];
      assign rdy_o                           = node_rdy[2*arb_pkg::N_REQ-2];
      assign node_ack[2*arb_pkg::N_REQ-2]    = ack_i;
   end

endmodule

`default_nettype wire

// ==== verilog/tree_node.sv ====
`timescale 1ns/1ps
`default_nettype none

module tree_node #(
   parameter bit enable_delay = 1'b0
) (
   input  logic          clk,
   input  logic          rst_n_i,

   input  arb_pkg::tag_t left_tag_i,
   input  logic          left_rdy_i,
   output logic          left_ack_o,

   input  arb_pkg::tag_t right_tag_i,
   input  logic          right_rdy_i,
   output logic          right_ack_o,

   output arb_pkg::tag_t tag_o,
   output logic          rdy_o,
   input  logic          ack_i
);

   // preference register, low means the left side goes first
   logic          pref_q;
   logic          pick_right;
   arb_pkg::tag_t mux_tag;
   logic          mux_rdy;
   logic          mux_ack;
   logic          take;

   // the right side wins when it is alone or when it is preferred
   assign pick_right = right_rdy_i & (~left_rdy_i | pref_q);

   assign mux_tag = pick_right ? right_tag_i : left_tag_i;
   assign mux_rdy = left_rdy_i | right_rdy_i;

   // only the chosen side sees the ack
   assign left_ack_o  = mux_ack & left_rdy_i & ~pick_right;
   assign right_ack_o = mux_ack & pick_right;

   assign take = mux_rdy & mux_ack;

   // serving the preferred side hands the preference to the other one
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pref_q <= 1'b0;
      end else if (take && (pick_right == pref_q)) begin
         pref_q <= ~pref_q;
      end
   end

   if (enable_delay) begin : g_delay
      pipe_stage #(
         .payload_t (arb_pkg::tag_t)
      ) stage_i (
         .clk           (clk),
         .rst_n_i       (rst_n_i),
         .in_rdy_i      (mux_rdy),
         .in_payload_i  (mux_tag),
         .in_ack_o      (mux_ack),
         .out_rdy_o     (rdy_o),
         .out_payload_o (tag_o),
         .out_ack_i     (ack_i)
      );
   end else begin : g_comb
      // no stage here, the parent sees the choice in the same cycle
      assign tag_o   = mux_tag;
      assign rdy_o   = mux_rdy;
      assign mux_ack = ack_i;
   end

endmodule

`default_nettype wire
